//--- compile.f
+incdir+.
makehint_pkg.sv
makehint_cfg.sv
makehint_hint_calc.sv
makehint_ctrl.sv
makehint_sample_buffer.sv
makehint_top.sv
makehint_tb.sv

//--- Bender.yml
package:
  name: makehint

sources:
  - files:
      - makehint_pkg.sv
      - makehint_cfg.sv
      - makehint_hint_calc.sv
      - makehint_ctrl.sv
      - makehint_sample_buffer.sv
      - makehint_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - makehint_tb.sv

//--- makehint_tb_tasks.svh
// Directed tests for the ML-DSA hint stage
// Stimulus generator, reference model of the hint rule and output checks

`ifndef MAKEHINT_TB_TASKS_SVH
`define MAKEHINT_TB_TASKS_SVH

  // Linear congruential generator that returns a 31 bit non-negative value
  function automatic int lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'(lcg_state >> 1);
  endfunction

  // A hint is due outside the open range, or on -gamma2 when r1 is nonzero
  function automatic bit hint_needed(input int r0, input int r1, input int g2);
    return (r0 > g2) || (r0 < -g2) || ((r0 == -g2) && (r1 != 0));
  endfunction

  // Mostly small r0 values, with one in sixteen placed a few steps off +-gamma2
  task automatic fill_random(input int npoly, input int g2);
    int r0;
    for (int i = 0; i < npoly * makehint_pkg::COEFFS_PER_POLY; i++) begin
      if (lcg_next() % 16 == 0) begin
        r0 = (lcg_next() % 2 == 1) ? g2 : -g2;
        r0 = r0 + lcg_next() % 9 - 4;
      end else begin
        r0 = lcg_next() % g2 - g2 / 2;
      end
      stim_r0[i] = r0;
      stim_r1[i] = (lcg_next() % 4 == 0) ? 0 : lcg_next() % 44;
    end
  endtask

  // Hint positions in order, capped at omega, then zeros up to omega
  task automatic build_expected(input int npoly, input int g2, input int omega);
    int total;
    int n;
    exp_idx.delete();
    exp_cnt.delete();
    total = 0;
    for (int p = 0; p < npoly; p++) begin
      for (int c = 0; c < makehint_pkg::COEFFS_PER_POLY; c++) begin
        n = p * makehint_pkg::COEFFS_PER_POLY + c;
        if (hint_needed(stim_r0[n], stim_r1[n], g2)) begin
          if (total < omega) exp_idx.push_back(c);
          total++;
        end
      end
      exp_cnt.push_back((total < omega) ? total : omega);
    end
    while (exp_idx.size() < omega) exp_idx.push_back(0);
    // Invalid flag goes in bit 8 when hints were dropped and the count sits below it
    exp_status = ((total > omega) ? 32'h100 : 0) | exp_cnt[$];
  endtask

  task automatic write_reg(input makehint_pkg::cfg_addr_e addr, input logic [31:0] data);
    @(negedge clk);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    @(negedge clk);
    cfg_we_i = 1'b0;
  endtask

  task automatic check_reg(input makehint_pkg::cfg_addr_e addr, input logic [31:0] exp,
                           input string name);
    logic [31:0] got;
    @(negedge clk);
    cfg_we_i   = 1'b0;
    cfg_addr_i = addr;
    @(posedge clk);
    got = cfg_rdata_o;
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR cfg_rdata_o %s: expected 0x%08h got 0x%08h", name, exp, got);
    end
  endtask

  task automatic pulse_start();
    @(negedge clk);
    start_i = 1'b1;
    @(negedge clk);
    start_i = 1'b0;
  endtask

  // One beat per cycle with NUM_WR consecutive coefficients each
  task automatic drive_beats(input int first, input int count);
    for (int b = first; b < first + count; b++) begin
      @(negedge clk);
      coeff_valid_i = 1'b1;
      for (int lane = 0; lane < NUM_WR; lane++) begin
        r0_i[lane] = makehint_pkg::coeff_t'(stim_r0[b * NUM_WR + lane]);
        r1_i[lane] = makehint_pkg::high_t'(stim_r1[b * NUM_WR + lane]);
      end
    end
    @(negedge clk);
    coeff_valid_i = 1'b0;
  endtask

  task automatic wait_done(input int limit);
    int  n;
    bit  got;
    got = 1'b0;
    for (n = 0; (n < limit) && !got; n++) begin
      @(posedge clk);
      got = done_o;
    end
    checks++;
    if (!got) begin
      errors++;
      $display("done_o did not rise within %0d cycles", limit);
    end
  endtask

  task automatic compare_outputs();
    checks++;
    if (seen_idx.size() != exp_idx.size()) begin
      errors++;
      $display("ERROR index count: expected 0x%0h got 0x%0h", exp_idx.size(), seen_idx.size());
    end else begin
      for (int i = 0; i < exp_idx.size(); i++) begin
        checks++;
        if (seen_idx[i] != exp_idx[i]) begin
          errors++;
          $display("ERROR data_o entry %0d: expected 0x%02h got 0x%02h", i, exp_idx[i],
                   seen_idx[i]);
        end
      end
    end
    // The last entry written to the buffer is the last one of the stream
    checks++;
    if (max_index_o !== makehint_pkg::index_t'(exp_idx[$])) begin
      errors++;
      $display("ERROR max_index_o: expected 0x%02h got 0x%02h", exp_idx[$], max_index_o);
    end
    checks++;
    if (seen_cnt.size() != exp_cnt.size()) begin
      errors++;
      $display("ERROR poly_count_valid_o pulses: expected 0x%0h got 0x%0h", exp_cnt.size(),
               seen_cnt.size());
    end else begin
      for (int i = 0; i < exp_cnt.size(); i++) begin
        checks++;
        if (seen_cnt[i] != exp_cnt[i]) begin
          errors++;
          $display("ERROR poly_count_o poly %0d: expected 0x%02h got 0x%02h", i, exp_cnt[i],
                   seen_cnt[i]);
        end
      end
    end
  endtask

  // Full signature run from start through all beats to done and drain, then stream and STATUS
  task automatic run_signature(input int npoly, input int g2, input int omega);
    build_expected(npoly, g2, omega);
    seen_idx.delete();
    seen_cnt.delete();
    pulse_start();
    drive_beats(0, npoly * makehint_pkg::COEFFS_PER_POLY / NUM_WR);
    wait_done(100);
    // The buffer holds less than NUM_RD once omega entries are out
    repeat (3) @(posedge clk);
    compare_outputs();
    check_reg(makehint_pkg::STATUS, exp_status, "STATUS");
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic register_access();
    int e;
    e = errors;
    check_reg(makehint_pkg::CTRL, 32'h40, "CTRL");
    check_reg(makehint_pkg::OMEGA, 32'h50, "OMEGA");
    check_reg(makehint_pkg::STATUS, 32'h0, "STATUS");
    write_reg(makehint_pkg::CTRL, 32'h31);
    write_reg(makehint_pkg::OMEGA, 32'h24);
    check_reg(makehint_pkg::CTRL, 32'h31, "CTRL");
    check_reg(makehint_pkg::OMEGA, 32'h24, "OMEGA");
    write_reg(makehint_pkg::CTRL, 32'h40);
    write_reg(makehint_pkg::OMEGA, 32'h50);
    check_reg(makehint_pkg::CTRL, 32'h40, "CTRL");
    report_test("register access", e);
  endtask

  task automatic random_polys();
    int e;
    e = errors;
    fill_random(4, G88);
    run_signature(4, G88, 80);
    report_test("random polynomials", e);
  endtask

  // Coefficients placed exactly on and next to the gamma2 boundaries
  task automatic gamma2_boundaries();
    int e;
    e = errors;
    write_reg(makehint_pkg::CTRL, 32'h11);
    for (int i = 0; i < makehint_pkg::COEFFS_PER_POLY; i++) begin
      stim_r0[i] = 0;
      stim_r1[i] = lcg_next() % 44;
    end
    stim_r0[0]   = G32;
    stim_r0[1]   = -G32;
    stim_r1[1]   = 0;
    stim_r0[2]   = -G32;
    stim_r1[2]   = 3;
    stim_r0[3]   = G32 + 1;
    stim_r0[4]   = -G32 - 1;
    // Above the small gamma2 but inside the large one
    stim_r0[5]   = G88 + 1;
    stim_r0[255] = -G32;
    stim_r1[255] = 1;
    run_signature(1, G32, 80);
    write_reg(makehint_pkg::CTRL, 32'h40);
    report_test("gamma2 boundaries", e);
  endtask

  // Two hints out of every three coefficients against an omega of 16
  task automatic omega_overflow();
    int e;
    e = errors;
    write_reg(makehint_pkg::CTRL, 32'h10);
    write_reg(makehint_pkg::OMEGA, 32'h10);
    for (int i = 0; i < makehint_pkg::COEFFS_PER_POLY; i++) begin
      stim_r0[i] = (i % 3 == 0) ? 0 : G88 + 1;
      stim_r1[i] = 0;
    end
    run_signature(1, G88, 16);
    write_reg(makehint_pkg::CTRL, 32'h40);
    write_reg(makehint_pkg::OMEGA, 32'h50);
    report_test("omega overflow", e);
  endtask

  task automatic zeroize_midstream();
    int e;
    e = errors;
    fill_random(4, G88);
    // Every lane of the last two beats needs a hint so the buffer is busy at zeroize
    for (int i = 94 * NUM_WR; i < 96 * NUM_WR; i++) begin
      stim_r0[i] = G88 + 1;
    end
    pulse_start();
    // Zeroize comes halfway through the second polynomial while the last beat is in flight
    drive_beats(0, 96);
    zeroize_i = 1'b1;
    @(negedge clk);
    zeroize_i = 1'b0;
    seen_idx.delete();
    seen_cnt.delete();
    for (int n = 0; n < 10; n++) begin
      @(posedge clk);
      checks++;
      if (data_valid_o || poly_count_valid_o || done_o) begin
        errors++;
        $display("Output activity seen %0d cycles after zeroize", n);
      end
    end
    check_reg(makehint_pkg::STATUS, 32'h0, "STATUS");
    check_reg(makehint_pkg::CTRL, 32'h40, "CTRL");
    fill_random(4, G88);
    run_signature(4, G88, 80);
    report_test("zeroize mid-stream", e);
  endtask

`endif

//--- makehint_tb.sv
// Testbench for the ML-DSA hint stage
// Clock, reset, DUT, output monitor and the directed test sequence

`timescale 1ns/100ps

module makehint_tb;

  localparam int NUM_WR           = 4;
  localparam int NUM_RD           = 4;
  localparam int OPT_BUFFER_DEPTH = 0;
  localparam int MAX_COEFFS       = 4 * makehint_pkg::COEFFS_PER_POLY;
  localparam int G88              = makehint_pkg::GAMMA2_88;
  localparam int G32              = makehint_pkg::GAMMA2_32;

  logic                                clk;
  logic                                rst_b;
  logic                                zeroize_i;
  logic                                start_i;
  logic                                cfg_we_i;
  makehint_pkg::cfg_addr_e             cfg_addr_i;
  logic                 [31:0]         cfg_wdata_i;
  logic                 [31:0]         cfg_rdata_o;
  logic                                coeff_valid_i;
  makehint_pkg::coeff_t [NUM_WR-1:0]   r0_i;
  makehint_pkg::high_t  [NUM_WR-1:0]   r1_i;
  logic                                data_valid_o;
  makehint_pkg::index_t [NUM_RD-1:0]   data_o;
  makehint_pkg::index_t                max_index_o;
  makehint_pkg::count_t                poly_count_o;
  logic                                poly_count_valid_o;
  logic                                done_o;

  // Everything the DUT released in order of appearance
  int          seen_idx[$];
  int          seen_cnt[$];
  // Reference stream with per polynomial counts and the STATUS word
  int          exp_idx[$];
  int          exp_cnt[$];
  int          exp_status;
  // Coefficient stimulus stored polynomial after polynomial
  int          stim_r0[MAX_COEFFS];
  int          stim_r1[MAX_COEFFS];
  int unsigned lcg_state;
  int          errors;
  int          checks;

  makehint_top #(
    .NUM_WR          (NUM_WR),
    .NUM_RD          (NUM_RD),
    .OPT_BUFFER_DEPTH(OPT_BUFFER_DEPTH)
  ) i_makehint_top (
    .clk, .rst_b, .zeroize_i, .start_i,
    .cfg_we_i, .cfg_addr_i, .cfg_wdata_i, .cfg_rdata_o,
    .coeff_valid_i, .r0_i, .r1_i,
    .data_valid_o, .data_o, .max_index_o,
    .poly_count_o, .poly_count_valid_o, .done_o
  );

  `include "makehint_tb_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Outputs are sampled on the rising edge, before the registers update
  always @(posedge clk) begin
    if (data_valid_o) begin
      for (int i = 0; i < NUM_RD; i++) begin
        seen_idx.push_back(int'(data_o[i]));
      end
    end
    if (poly_count_valid_o) begin
      seen_cnt.push_back(int'(poly_count_o));
    end
  end

  initial begin
    rst_b         = 1'b0;
    zeroize_i     = 1'b0;
    start_i       = 1'b0;
    cfg_we_i      = 1'b0;
    cfg_addr_i    = makehint_pkg::CTRL;
    cfg_wdata_i   = '0;
    coeff_valid_i = 1'b0;
    r0_i          = '0;
    r1_i          = '0;
    lcg_state     = 90;
    errors        = 0;
    checks        = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_b = 1'b1;

    register_access();
    random_polys();
    gamma2_boundaries();
    omega_overflow();
    zeroize_midstream();

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- makehint_top.sv
// ML-DSA hint stage top level
// Hint decision, omega limiting, zero padding and index packing behind a small register block

`timescale 1ns/100ps

module makehint_top #(
  parameter int NUM_WR           = 4,
  parameter int NUM_RD           = 4,
  parameter int OPT_BUFFER_DEPTH = 0
) (
  input  logic                                clk,
  input  logic                                rst_b,
  input  logic                                zeroize_i,
  input  logic                                start_i,
  input  logic                                cfg_we_i,
  input  makehint_pkg::cfg_addr_e             cfg_addr_i,
  input  logic                 [31:0]         cfg_wdata_i,
  output logic                 [31:0]         cfg_rdata_o,
  input  logic                                coeff_valid_i,
  input  makehint_pkg::coeff_t [NUM_WR-1:0]   r0_i,
  input  makehint_pkg::high_t  [NUM_WR-1:0]   r1_i,
  output logic                                data_valid_o,
  output makehint_pkg::index_t [NUM_RD-1:0]   data_o,
  output makehint_pkg::index_t                max_index_o,
  output makehint_pkg::count_t                poly_count_o,
  output logic                                poly_count_valid_o,
  output logic                                done_o
);

  makehint_pkg::coeff_t               gamma2;
  makehint_pkg::count_t               omega;
  logic [3:0]                         num_poly;
  logic                               invalid;
  makehint_pkg::count_t               total;
  logic [NUM_WR-1:0]                  hint_valid;
  makehint_pkg::index_t [NUM_WR-1:0]  hint_idx;
  logic                               beat;
  logic [NUM_WR-1:0]                  wr_valid;
  makehint_pkg::index_t [NUM_WR-1:0]  wr_data;
  logic                               buffer_full;

  makehint_cfg i_makehint_cfg (
    .clk, .rst_b, .zeroize_i, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i, .cfg_rdata_o,
    .invalid_i (invalid),
    .total_i   (total),
    .gamma2_o  (gamma2),
    .omega_o   (omega),
    .num_poly_o(num_poly)
  );

  makehint_hint_calc #(.NUM_WR(NUM_WR)) i_makehint_hint_calc (
    .clk, .rst_b, .zeroize_i, .coeff_valid_i, .r0_i, .r1_i,
    .gamma2_i    (gamma2),
    .hint_valid_o(hint_valid),
    .hint_idx_o  (hint_idx),
    .beat_o      (beat)
  );

  makehint_ctrl #(.NUM_WR(NUM_WR)) i_makehint_ctrl (
    .clk, .rst_b, .zeroize_i, .start_i,
    .beat_i       (beat),
    .hint_valid_i (hint_valid),
    .hint_idx_i   (hint_idx),
    .omega_i      (omega),
    .num_poly_i   (num_poly),
    .buffer_full_i(buffer_full),
    .wr_valid_o   (wr_valid),
    .wr_data_o    (wr_data),
    .poly_count_o, .poly_count_valid_o,
    .total_o      (total),
    .invalid_o    (invalid),
    .done_o
  );

  makehint_sample_buffer #(
    .NUM_WR          (NUM_WR),
    .NUM_RD          (NUM_RD),
    .OPT_BUFFER_DEPTH(OPT_BUFFER_DEPTH)
  ) i_makehint_sample_buffer (
    .clk, .rst_b, .zeroize_i,
    .data_valid_i (wr_valid),
    .data_i       (wr_data),
    .buffer_full_o(buffer_full),
    .data_valid_o, .data_o, .max_index_o
  );

endmodule

//--- makehint_sample_buffer.sv
// Hint index sample buffer
// Packs up to NUM_WR valid indices per cycle behind the held entries
// and releases NUM_RD of them once that many are held

`timescale 1ns/100ps

module makehint_sample_buffer #(
  parameter int NUM_WR           = 4,
  parameter int NUM_RD           = 4,
  parameter int OPT_BUFFER_DEPTH = 0
) (
  input  logic                                clk,
  input  logic                                rst_b,
  input  logic                                zeroize_i,
  input  logic                 [NUM_WR-1:0]   data_valid_i,
  input  makehint_pkg::index_t [NUM_WR-1:0]   data_i,
  output logic                                buffer_full_o,
  output logic                                data_valid_o,
  output makehint_pkg::index_t [NUM_RD-1:0]   data_o,
  output makehint_pkg::index_t                max_index_o
);

  localparam int BUFFER_DEPTH = NUM_WR + NUM_RD + OPT_BUFFER_DEPTH;
  localparam int CNT_W        = $clog2(BUFFER_DEPTH + 1);
  localparam int DATA_W       = $bits(makehint_pkg::index_t);

  // Entries 0 to count_q-1 are valid, entry 0 is the oldest
  makehint_pkg::index_t [BUFFER_DEPTH-1:0] buf_q;
  makehint_pkg::index_t [BUFFER_DEPTH-1:0] buf_shift;
  makehint_pkg::index_t [BUFFER_DEPTH-1:0] buf_d;
  logic [CNT_W-1:0]                        count_q;
  logic [CNT_W-1:0]                        count_d;
  // Occupancy left after this cycle's read, where new entries go
  logic [CNT_W-1:0]                        base;
  logic [CNT_W-1:0]                        wr_ptr;
  makehint_pkg::index_t                    max_index_d;
  logic                                    buffer_rd;
  logic                                    buffer_wr;

  // Read whenever a full output word is held
  always_comb buffer_rd = (count_q >= CNT_W'(NUM_RD));
  always_comb base = buffer_rd ? count_q - CNT_W'(NUM_RD) : count_q;

  // Full when a complete write beat would not fit behind the remaining entries.
  // With NUM_WR equal to NUM_RD and no spare depth this never rises
  always_comb buffer_full_o = (int'(base) > BUFFER_DEPTH - NUM_WR);

  always_comb buffer_wr = (|data_valid_i) && !buffer_full_o;

  // Drop the oldest NUM_RD entries on a read
  always_comb begin
    buf_shift = buffer_rd ? (buf_q >> (NUM_RD * DATA_W)) : buf_q;
  end

  // Compact valid lanes in lane order and append them after the kept entries
  always_comb begin
    buf_d       = buf_shift;
    wr_ptr      = base;
    max_index_d = max_index_o;
    for (int lane = 0; lane < NUM_WR; lane++) begin
      if (buffer_wr && data_valid_i[lane]) begin
        buf_d[wr_ptr] = data_i[lane];
        // Last valid lane wins
        max_index_d   = data_i[lane];
        wr_ptr        = wr_ptr + 1'b1;
      end
    end
    count_d = wr_ptr;
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      count_q     <= '0;
      max_index_o <= '0;
    end else if (zeroize_i) begin
      count_q     <= '0;
      max_index_o <= '0;
    end else begin
      count_q     <= count_d;
      max_index_o <= max_index_d;
    end
  end

  // Storage only matters below count_q, so it needs no clear
  always_ff @(posedge clk) begin
    buf_q <= buf_d;
  end

  always_comb data_valid_o = buffer_rd;
  always_comb data_o = buf_q[NUM_RD-1:0];

endmodule

//--- makehint_ctrl.sv
// Hint stage controller
// Counts beats and polynomials, enforces the omega limit and pads with zero indices

`timescale 1ns/100ps

module makehint_ctrl #(
  parameter int NUM_WR = 4
) (
  input  logic                                clk,
  input  logic                                rst_b,
  input  logic                                zeroize_i,
  input  logic                                start_i,
  input  logic                                beat_i,
  input  logic                 [NUM_WR-1:0]   hint_valid_i,
  input  makehint_pkg::index_t [NUM_WR-1:0]   hint_idx_i,
  input  makehint_pkg::count_t                omega_i,
  input  logic                 [3:0]          num_poly_i,
  input  logic                                buffer_full_i,
  output logic                 [NUM_WR-1:0]   wr_valid_o,
  output makehint_pkg::index_t [NUM_WR-1:0]   wr_data_o,
  output makehint_pkg::count_t                poly_count_o,
  output logic                                poly_count_valid_o,
  output makehint_pkg::count_t                total_o,
  output logic                                invalid_o,
  output logic                                done_o
);

  localparam int BEATS  = makehint_pkg::COEFFS_PER_POLY / NUM_WR;
  localparam int BEAT_W = $clog2(BEATS);

  makehint_pkg::ctrl_state_e state_q;
  logic [BEAT_W-1:0]         beat_cnt_q;
  makehint_pkg::npoly_t      poly_cnt_q;
  // Entries written so far, hints plus padding
  makehint_pkg::count_t      fill_q;

  // One extra bit so the running sums cannot wrap
  logic [8:0]        hint_acc;
  logic [8:0]        pad_acc;
  logic [NUM_WR-1:0] hint_lanes;
  logic [NUM_WR-1:0] pad_lanes;
  logic              drop;
  logic              hint_go;
  logic              pad_go;
  logic              pad_last;
  logic              last_beat;
  logic              last_poly;

  always_comb hint_go = (state_q == makehint_pkg::HINTS) && beat_i;
  always_comb pad_go = (state_q == makehint_pkg::PAD) && !buffer_full_i;
  always_comb last_beat = (int'(beat_cnt_q) == BEATS - 1);
  always_comb last_poly = (poly_cnt_q == num_poly_i - 4'd1);

  // Accept hints in lane order until omega is reached, any further hint is dropped
  always_comb begin
    hint_acc   = {1'b0, total_o};
    hint_lanes = '0;
    drop       = 1'b0;
    for (int lane = 0; lane < NUM_WR; lane++) begin
      if (hint_valid_i[lane]) begin
        if (hint_acc < {1'b0, omega_i}) begin
          hint_lanes[lane] = 1'b1;
          hint_acc         = hint_acc + 9'd1;
        end else begin
          drop = 1'b1;
        end
      end
    end
  end

  // Fill the remaining room up to omega with zero indices
  always_comb begin
    pad_acc   = {1'b0, fill_q};
    pad_lanes = '0;
    for (int lane = 0; lane < NUM_WR; lane++) begin
      if (pad_acc < {1'b0, omega_i}) begin
        pad_lanes[lane] = 1'b1;
        pad_acc         = pad_acc + 9'd1;
      end
    end
    pad_last = pad_go && (pad_acc >= {1'b0, omega_i});
  end

  always_comb begin
    wr_valid_o = hint_go ? hint_lanes : (pad_go ? pad_lanes : '0);
    for (int lane = 0; lane < NUM_WR; lane++) begin
      wr_data_o[lane] = (state_q == makehint_pkg::PAD) ? '0 : hint_idx_i[lane];
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q <= makehint_pkg::IDLE;
      beat_cnt_q <= '0;
      poly_cnt_q <= '0;
      fill_q <= '0;
      total_o <= '0;
      invalid_o <= 1'b0;
      poly_count_valid_o <= 1'b0;
    end else if (zeroize_i) begin
      state_q <= makehint_pkg::IDLE;
      beat_cnt_q <= '0;
      poly_cnt_q <= '0;
      fill_q <= '0;
      total_o <= '0;
      invalid_o <= 1'b0;
      poly_count_valid_o <= 1'b0;
    end else begin
      poly_count_valid_o <= hint_go && last_beat;
      case (state_q)
        makehint_pkg::IDLE: begin
          // A new signature starts from clean counts and status
          if (start_i) begin
            state_q <= makehint_pkg::HINTS;
            beat_cnt_q <= '0;
            poly_cnt_q <= '0;
            total_o <= '0;
            invalid_o <= 1'b0;
          end
        end
        makehint_pkg::HINTS: begin
          if (beat_i) begin
            total_o <= hint_acc[7:0];
            invalid_o <= invalid_o | drop;
            beat_cnt_q <= last_beat ? '0 : beat_cnt_q + 1'b1;
            if (last_beat) begin
              poly_cnt_q <= poly_cnt_q + 4'd1;
              if (last_poly) begin
                state_q <= makehint_pkg::PAD;
                fill_q <= hint_acc[7:0];
              end
            end
          end
        end
        makehint_pkg::PAD: begin
          if (pad_go) begin
            fill_q <= pad_acc[7:0];
          end
          if (pad_last) begin
            state_q <= makehint_pkg::DONE;
          end
        end
        // DONE lasts one cycle and carries the done pulse
        default: state_q <= makehint_pkg::IDLE;
      endcase
    end
  end

  // Cumulative count captured at the last beat of each polynomial
  always_ff @(posedge clk) begin
    if (hint_go && last_beat) begin
      poly_count_o <= hint_acc[7:0];
    end
  end

  always_comb done_o = (state_q == makehint_pkg::DONE);

endmodule

//--- makehint_hint_calc.sv
// Per-lane hint decision for the ML-DSA hint stage
// Flags coefficients that need a hint and tags them with their position

`timescale 1ns/100ps

module makehint_hint_calc #(
  parameter int NUM_WR = 4
) (
  input  logic                                clk,
  input  logic                                rst_b,
  input  logic                                zeroize_i,
  input  logic                                coeff_valid_i,
  input  makehint_pkg::coeff_t [NUM_WR-1:0]   r0_i,
  input  makehint_pkg::high_t  [NUM_WR-1:0]   r1_i,
  input  makehint_pkg::coeff_t                gamma2_i,
  output logic                 [NUM_WR-1:0]   hint_valid_o,
  output makehint_pkg::index_t [NUM_WR-1:0]   hint_idx_o,
  output logic                                beat_o
);

  localparam int BEATS  = makehint_pkg::COEFFS_PER_POLY / NUM_WR;
  localparam int BEAT_W = $clog2(BEATS);

  logic [BEAT_W-1:0]                beat_cnt_q;
  logic [NUM_WR-1:0]                hint_d;
  makehint_pkg::index_t [NUM_WR-1:0] idx_d;
  // Signed working copies so that the compares below are signed
  makehint_pkg::coeff_t             r0_lane;
  makehint_pkg::coeff_t             neg_gamma2;

  always_comb begin
    neg_gamma2 = -gamma2_i;
    r0_lane    = '0;
    hint_d     = '0;
    idx_d      = '0;
    for (int lane = 0; lane < NUM_WR; lane++) begin
      r0_lane = r0_i[lane];
      // Hint when r0 leaves the open range, or sits on -gamma2 with nonzero r1
      hint_d[lane] = (r0_lane > gamma2_i) || (r0_lane < neg_gamma2) ||
                     ((r0_lane == neg_gamma2) && (r1_i[lane] != '0));
      // Position is beat times lane count plus lane number
      idx_d[lane] = makehint_pkg::index_t'(int'(beat_cnt_q) * NUM_WR + lane);
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      beat_cnt_q   <= '0;
      hint_valid_o <= '0;
      beat_o       <= 1'b0;
    end else if (zeroize_i) begin
      beat_cnt_q   <= '0;
      hint_valid_o <= '0;
      beat_o       <= 1'b0;
    end else begin
      beat_o       <= coeff_valid_i;
      hint_valid_o <= coeff_valid_i ? hint_d : '0;
      if (coeff_valid_i) begin
        // Wrap at the end of the polynomial
        beat_cnt_q <= (int'(beat_cnt_q) == BEATS - 1) ? '0 : beat_cnt_q + 1'b1;
      end
    end
  end

  // Index payload is only meaningful with its valid bit
  always_ff @(posedge clk) begin
    if (coeff_valid_i) begin
      hint_idx_o <= idx_d;
    end
  end

endmodule

//--- makehint_cfg.sv
// Hint stage configuration and status registers
// Holds gamma2 select, polynomial count and omega, returns status read-back

`timescale 1ns/100ps

module makehint_cfg (
  input  logic                    clk,
  input  logic                    rst_b,
  input  logic                    zeroize_i,
  input  logic                    cfg_we_i,
  input  makehint_pkg::cfg_addr_e cfg_addr_i,
  input  logic [31:0]             cfg_wdata_i,
  output logic [31:0]             cfg_rdata_o,
  input  logic                    invalid_i,
  input  makehint_pkg::count_t    total_i,
  output makehint_pkg::coeff_t    gamma2_o,
  output makehint_pkg::count_t    omega_o,
  output logic [3:0]              num_poly_o
);

  // Low selects GAMMA2_88, high selects GAMMA2_32
  logic                 gamma2_sel_q;
  makehint_pkg::npoly_t num_poly_q;
  makehint_pkg::count_t omega_q;

  // Zeroize brings the block back to the parameter set of reset
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      gamma2_sel_q <= 1'b0;
      num_poly_q   <= 4'd4;
      omega_q      <= 8'd80;
    end else if (zeroize_i) begin
      gamma2_sel_q <= 1'b0;
      num_poly_q   <= 4'd4;
      omega_q      <= 8'd80;
    end else if (cfg_we_i) begin
      case (cfg_addr_i)
        makehint_pkg::CTRL: begin
          gamma2_sel_q <= cfg_wdata_i[makehint_pkg::CTRL_SEL_BIT];
          num_poly_q   <= cfg_wdata_i[makehint_pkg::CTRL_NPOLY_LSB +: 4];
        end
        makehint_pkg::OMEGA: begin
          omega_q <= cfg_wdata_i[7:0];
        end
        // STATUS is read only
        default: ;
      endcase
    end
  end

  // Map the select bit onto the actual constant
  always_comb gamma2_o = gamma2_sel_q ? makehint_pkg::GAMMA2_32 : makehint_pkg::GAMMA2_88;
  always_comb omega_o = omega_q;
  always_comb num_poly_o = num_poly_q;

  // Read-back is combinational from the address
  always_comb begin
    cfg_rdata_o = '0;
    case (cfg_addr_i)
      makehint_pkg::CTRL: begin
        cfg_rdata_o[makehint_pkg::CTRL_SEL_BIT]        = gamma2_sel_q;
        cfg_rdata_o[makehint_pkg::CTRL_NPOLY_LSB +: 4] = num_poly_q;
      end
      makehint_pkg::OMEGA: begin
        cfg_rdata_o[7:0] = omega_q;
      end
      makehint_pkg::STATUS: begin
        // Invalid flag above the running total
        cfg_rdata_o[makehint_pkg::STATUS_INVALID_BIT] = invalid_i;
        cfg_rdata_o[7:0]                              = total_i;
      end
      default: cfg_rdata_o = '0;
    endcase
  end

endmodule

//--- makehint_pkg.sv
// ML-DSA hint stage shared definitions
// Widths, gamma2 constants, register map and controller states

package makehint_pkg;

  // Signed low part r0 of a decomposed coefficient
  typedef logic signed [22:0] coeff_t;
  // High part r1 of a decomposed coefficient
  typedef logic [5:0] high_t;
  // Coefficient position within a polynomial, also the buffer entry width
  typedef logic [7:0] index_t;
  // Hint count, never above omega
  typedef logic [7:0] count_t;
  // Number of polynomials per signature
  typedef logic [3:0] npoly_t;

  // Legal gamma2 values, (q-1)/88 and (q-1)/32 with q = 8380417
  localparam coeff_t GAMMA2_88 = 23'd95232;
  localparam coeff_t GAMMA2_32 = 23'd261888;

  localparam int COEFFS_PER_POLY = 256;

  // Field positions inside the 32 bit register words
  localparam int CTRL_SEL_BIT       = 0;
  localparam int CTRL_NPOLY_LSB     = 4;
  localparam int STATUS_INVALID_BIT = 8;

  typedef enum logic [1:0] {
    CTRL   = 2'd0,
    OMEGA  = 2'd1,
    STATUS = 2'd2
  } cfg_addr_e;

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    HINTS = 2'd1,
    PAD   = 2'd2,
    DONE  = 2'd3
  } ctrl_state_e;

endpackage
